// ==== verilog/matcher_consts.svh ====
`ifndef MATCHER_CONSTS_SVH
`define MATCHER_CONSTS_SVH

// character and memory geometry
`define DATA_WIDTH 8
`define VOCAB_ADDR_WIDTH 6
`define WORD_ADDR_WIDTH 4
`define INDEX_WIDTH 6

// wishbone bus widths
`define WB_ADDR_WIDTH 8
`define WB_DATA_WIDTH 8

// string terminator
`define NULL_CHAR 8'h00

// memory windows, vocab takes 64 bytes, query 16
`define VOCAB_BASE 8'h00
`define WORD_BASE 8'h40

// register map
`define CTRL_ADDR 8'h80
`define STATUS_ADDR 8'h81
`define RESULT_ADDR 8'h82

`endif

// ==== verilog/wb_pkg.sv ====
`include "matcher_consts.svh"

package wb_pkg;

    // one classic cycle request, held by the master until ack
    typedef struct packed {
        logic [`WB_ADDR_WIDTH-1:0] adr;
        logic [`WB_DATA_WIDTH-1:0] dat;
        logic                      we;
        logic                      stb;
        logic                      cyc;
    } wb_req_t;

    // slave reply, dat only meaningful while ack is high
    typedef struct packed {
        logic [`WB_DATA_WIDTH-1:0] dat;
        logic                      ack;
    } wb_rsp_t;

    // decoded access target
    typedef enum logic [2:0] {
        REGION_VOCAB,
        REGION_WORD,
        REGION_CTRL,
        REGION_STATUS,
        REGION_RESULT,
        REGION_NONE
    } wb_region_e;

endpackage

// ==== verilog/match_pkg.sv ====
`include "matcher_consts.svh"

package match_pkg;

    // walker states, fetch waits out the ram read latency
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_COMPARE,
        ST_SKIP,
        ST_SKIP_FETCH,
        ST_DONE
    } match_state_e;

    // write into one of the two memories
    // the query ram only looks at the low address bits
    typedef struct packed {
        logic                         en;
        logic [`VOCAB_ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0]       data;
    } mem_wr_t;

    // search outcome
    typedef struct packed {
        logic                    found;
        logic [`INDEX_WIDTH-1:0] index;
    } match_result_t;

endpackage

// ==== verilog/sram.sv ====
`timescale 1ns/1ps

module sram #(
    parameter int depth_log2 = 6,
    parameter int width = 8
) (
    input  logic                  clk,
    input  match_pkg::mem_wr_t    wr,
    input  logic [depth_log2-1:0] rd_addr,
    output logic [width-1:0]      rd_data
);

    logic [width-1:0] mem [2**depth_log2];

    // write port, narrower rams drop the upper address bits
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr[depth_log2-1:0]] <= wr.data[width-1:0];
        end
    end

    // registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== verilog/char_incr.sv ====
`timescale 1ns/1ps

module char_incr #(
    parameter int addr_width = 6
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear,
    input  logic                  step,
    output logic [addr_width-1:0] addr,
    output logic                  overflow
);

    logic at_last;

    assign at_last = (addr == {addr_width{1'b1}});

    // address counter, clear wins over step
    always_ff @(posedge clk) begin
        if (rst) begin
            addr <= '0;
        end else if (clear) begin
            addr <= '0;
        end else if (step) begin
            addr <= addr + 1'b1;
        end
    end

    // sticky flag, set when stepping off the last address
    always_ff @(posedge clk) begin
        if (rst) begin
            overflow <= 1'b0;
        end else if (clear) begin
            overflow <= 1'b0;
        end else if (step && at_last) begin
            overflow <= 1'b1;
        end
    end

endmodule

// ==== verilog/matcher.sv ====
`timescale 1ns/1ps

`include "matcher_consts.svh"

module matcher (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic [`DATA_WIDTH-1:0]   vocab_char,
    input  logic [`DATA_WIDTH-1:0]   word_char,
    input  logic                     vocab_overflow,
    output logic                     vocab_clear,
    output logic                     vocab_step,
    output logic                     word_clear,
    output logic                     word_step,
    output logic                     busy,
    output logic                     done_pulse,
    output match_pkg::match_result_t result
);

    import match_pkg::*;

    match_state_e state;
    match_state_e next_state;

    logic                    first_q;
    logic                    found_q;
    logic [`INDEX_WIDTH-1:0] idx_q;

    logic vocab_null;
    logic word_null;
    logic start_ok;
    logic hit;
    logic next_word;

    assign vocab_null = (vocab_char == `NULL_CHAR);
    assign word_null  = (word_char == `NULL_CHAR);

    // a new search may begin from idle or in the done cycle
    assign start_ok = start && (state == ST_IDLE || state == ST_DONE);

    assign busy       = (state != ST_IDLE) && (state != ST_DONE);
    assign done_pulse = (state == ST_DONE);
    assign result     = '{found: found_q, index: idx_q};

    always_comb begin
        next_state  = state;
        vocab_clear = 1'b0;
        vocab_step  = 1'b0;
        word_clear  = 1'b0;
        word_step   = 1'b0;
        hit         = 1'b0;
        next_word   = 1'b0;
        case (state)
            ST_IDLE, ST_DONE: begin
                if (start) begin
                    vocab_clear = 1'b1;
                    word_clear  = 1'b1;
                    next_state  = ST_FETCH;
                end else begin
                    next_state  = ST_IDLE;
                end
            end
            ST_FETCH: begin
                next_state = ST_COMPARE;
            end
            ST_COMPARE: begin
                // end of list, ran off memory, or empty query
                if (vocab_overflow || (first_q && (vocab_null || word_null))) begin
                    next_state = ST_DONE;
                end else if (vocab_char == word_char) begin
                    if (vocab_null) begin
                        hit        = 1'b1;
                        next_state = ST_DONE;
                    end else begin
                        vocab_step = 1'b1;
                        word_step  = 1'b1;
                        next_state = ST_FETCH;
                    end
                end else begin
                    // ram output holds, skip can test this same char
                    next_state = ST_SKIP;
                end
            end
            ST_SKIP: begin
                if (vocab_overflow) begin
                    next_state = ST_DONE;
                end else if (vocab_null) begin
                    // step past the terminator onto the next word
                    vocab_step = 1'b1;
                    word_clear = 1'b1;
                    next_word  = 1'b1;
                    next_state = ST_FETCH;
                end else begin
                    vocab_step = 1'b1;
                    next_state = ST_SKIP_FETCH;
                end
            end
            ST_SKIP_FETCH: begin
                next_state = ST_SKIP;
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            first_q <= 1'b0;
            found_q <= 1'b0;
            idx_q   <= '0;
        end else begin
            state <= next_state;
            if (start_ok) begin
                first_q <= 1'b1;
                found_q <= 1'b0;
                idx_q   <= '0;
            end else begin
                if (word_step) begin
                    first_q <= 1'b0;
                end
                if (next_word) begin
                    first_q <= 1'b1;
                    idx_q   <= idx_q + 1'b1;
                end
                if (hit) begin
                    found_q <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== verilog/wb_regs.sv ====
`timescale 1ns/1ps

`include "matcher_consts.svh"

module wb_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  wb_pkg::wb_req_t          req,
    output wb_pkg::wb_rsp_t          rsp,
    output match_pkg::mem_wr_t       vocab_wr,
    output match_pkg::mem_wr_t       word_wr,
    output logic                     start,
    input  logic                     busy,
    input  logic                     done_pulse,
    input  match_pkg::match_result_t result
);

    import wb_pkg::*;
    import match_pkg::*;

    wb_region_e region;

    logic                      ack_q;
    logic [`WB_DATA_WIDTH-1:0] rd_q;
    logic                      done_q;
    match_result_t             result_q;
    logic                      new_access;
    logic                      wr_access;
    logic [`WB_ADDR_WIDTH-1:0] word_off;
    logic [`WB_DATA_WIDTH-1:0] rd_mux;

    // first cycle of a request, ack not yet given
    assign new_access = req.cyc && req.stb && !ack_q;
    assign wr_access  = new_access && req.we;
    assign word_off   = req.adr - `WORD_BASE;

    always_comb begin
        if (req.adr >= `VOCAB_BASE && req.adr < `WORD_BASE) begin
            region = REGION_VOCAB;
        end else if (req.adr >= `WORD_BASE &&
                     req.adr < `WORD_BASE + (1 << `WORD_ADDR_WIDTH)) begin
            region = REGION_WORD;
        end else if (req.adr == `CTRL_ADDR) begin
            region = REGION_CTRL;
        end else if (req.adr == `STATUS_ADDR) begin
            region = REGION_STATUS;
        end else if (req.adr == `RESULT_ADDR) begin
            region = REGION_RESULT;
        end else begin
            region = REGION_NONE;
        end
    end

    // memories are write-only, they read back as zero
    always_comb begin
        case (region)
            REGION_STATUS: rd_mux = {5'b0, result_q.found, done_q, busy};
            REGION_RESULT: rd_mux = {{(`WB_DATA_WIDTH - `INDEX_WIDTH){1'b0}}, result_q.index};
            default:       rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
            start <= 1'b0;
        end else begin
            ack_q <= new_access;
            start <= wr_access && region == REGION_CTRL && req.dat[0] && !busy;
        end
    end

    always_ff @(posedge clk) begin
        if (new_access) begin
            rd_q <= rd_mux;
        end
    end

    // window writes land in the ack cycle, dropped while searching
    always_ff @(posedge clk) begin
        if (rst) begin
            vocab_wr.en <= 1'b0;
            word_wr.en  <= 1'b0;
        end else begin
            vocab_wr.en <= wr_access && region == REGION_VOCAB && !busy;
            word_wr.en  <= wr_access && region == REGION_WORD && !busy;
        end
        vocab_wr.addr <= req.adr[`VOCAB_ADDR_WIDTH-1:0];
        vocab_wr.data <= req.dat;
        word_wr.addr  <= word_off[`VOCAB_ADDR_WIDTH-1:0];
        word_wr.data  <= req.dat;
    end

    // sticky done and latched result for status reads
    always_ff @(posedge clk) begin
        if (rst) begin
            done_q   <= 1'b0;
            result_q <= '0;
        end else if (start) begin
            done_q <= 1'b0;
        end else if (done_pulse) begin
            done_q   <= 1'b1;
            result_q <= result;
        end
    end

    assign rsp = '{dat: rd_q, ack: ack_q};

endmodule

// ==== verilog/word_match_top.sv ====
`timescale 1ns/1ps

`include "matcher_consts.svh"

module word_match_top (
    input  logic            clk,
    input  logic            rst,
    input  wb_pkg::wb_req_t wb_req,
    output wb_pkg::wb_rsp_t wb_rsp
);

    import match_pkg::*;

    mem_wr_t       vocab_wr;
    mem_wr_t       word_wr;
    match_result_t result;

    logic start;
    logic busy;
    logic done_pulse;

    logic [`VOCAB_ADDR_WIDTH-1:0] vocab_addr;
    logic [`WORD_ADDR_WIDTH-1:0]  word_addr;
    logic [`DATA_WIDTH-1:0]       vocab_char;
    logic [`DATA_WIDTH-1:0]       word_char;

    logic vocab_overflow;
    logic vocab_clear;
    logic vocab_step;
    logic word_clear;
    logic word_step;

    wb_regs wb_regs_i (
        .clk        (clk),
        .rst        (rst),
        .req        (wb_req),
        .rsp        (wb_rsp),
        .vocab_wr   (vocab_wr),
        .word_wr    (word_wr),
        .start      (start),
        .busy       (busy),
        .done_pulse (done_pulse),
        .result     (result)
    );

    sram #(
        .depth_log2 (`VOCAB_ADDR_WIDTH),
        .width      (`DATA_WIDTH)
    ) vocab_ram (
        .clk     (clk),
        .wr      (vocab_wr),
        .rd_addr (vocab_addr),
        .rd_data (vocab_char)
    );

    sram #(
        .depth_log2 (`WORD_ADDR_WIDTH),
        .width      (`DATA_WIDTH)
    ) word_ram (
        .clk     (clk),
        .wr      (word_wr),
        .rd_addr (word_addr),
        .rd_data (word_char)
    );

    char_incr #(
        .addr_width (`VOCAB_ADDR_WIDTH)
    ) vocab_incr (
        .clk      (clk),
        .rst      (rst),
        .clear    (vocab_clear),
        .step     (vocab_step),
        .addr     (vocab_addr),
        .overflow (vocab_overflow)
    );

    // query always ends in a terminator, its overflow goes nowhere
    char_incr #(
        .addr_width (`WORD_ADDR_WIDTH)
    ) word_incr (
        .clk      (clk),
        .rst      (rst),
        .clear    (word_clear),
        .step     (word_step),
        .addr     (word_addr),
        .overflow ()
    );

    matcher matcher_i (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .vocab_char     (vocab_char),
        .word_char      (word_char),
        .vocab_overflow (vocab_overflow),
        .vocab_clear    (vocab_clear),
        .vocab_step     (vocab_step),
        .word_clear     (word_clear),
        .word_step      (word_step),
        .busy           (busy),
        .done_pulse     (done_pulse),
        .result         (result)
    );

endmodule

// ==== testbench/tb_word_match.sv ====
`timescale 1ns/1ps

`include "matcher_consts.svh"

module tb_word_match;

    import wb_pkg::*;

    localparam int num_searches = 35;
    // memory loads, start, status polls outside the search, result read
    localparam int bus_accesses = num_searches * 85 + 10;
    localparam int cycle_limit  = num_searches * 300 + bus_accesses * 4;

    logic    clk;
    logic    rst;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    logic [7:0]  vocab_model [64];
    logic [7:0]  word_model [16];
    logic [31:0] lcg_state;
    int          vocab_pos;
    int          word_count;
    int          word_start [64];
    int          word_len [64];
    int          check_count;
    int          error_count;
    int          cycle_count;

    word_match_top word_match_top_i (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + next_rand() % (hi - lo + 1);
    endfunction

    function automatic logic [7:0] rand_letter(input int n);
        return 8'h61 + rand_range(0, n - 1);
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        $display("test %s finished, %0d errors", name, error_count - errors_before);
    endtask

    task automatic wb_write(input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk);
        wb_req <= '{adr: addr, dat: data, we: 1'b1, stb: 1'b1, cyc: 1'b1};
        do @(posedge clk); while (!wb_rsp.ack);
        wb_req <= '0;
    endtask

    task automatic wb_read(input logic [7:0] addr, output logic [7:0] data);
        @(posedge clk);
        wb_req <= '{adr: addr, dat: 8'h00, we: 1'b0, stb: 1'b1, cyc: 1'b1};
        do @(posedge clk); while (!wb_rsp.ack);
        data = wb_rsp.dat;
        wb_req <= '0;
    endtask

    // vocabulary building in the model
    task automatic new_vocab();
        vocab_pos  = 0;
        word_count = 0;
    endtask

    task automatic put_char(input logic [7:0] c);
        vocab_model[vocab_pos] = c;
        vocab_pos++;
    endtask

    task automatic close_word();
        word_len[word_count] = vocab_pos - word_start[word_count];
        put_char(8'h00);
        word_count++;
    endtask

    task automatic add_word(input string s);
        int i;
        word_start[word_count] = vocab_pos;
        for (i = 0; i < s.len(); i++) begin
            put_char(s[i]);
        end
        close_word();
    endtask

    task automatic add_random_word(input int len, input int letters);
        int i;
        word_start[word_count] = vocab_pos;
        for (i = 0; i < len; i++) begin
            put_char(rand_letter(letters));
        end
        close_word();
    endtask

    // empty word ends the list with random letters behind it
    task automatic close_vocab();
        int a;
        put_char(8'h00);
        for (a = vocab_pos; a < 64; a++) begin
            vocab_model[a] = rand_letter(3);
        end
    endtask

    task automatic build_vocab(input int nwords, input int minlen, input int maxlen);
        int w;
        int len;
        new_vocab();
        for (w = 0; w < nwords; w++) begin
            len = rand_range(minlen, maxlen);
            if (vocab_pos + len + 1 <= 62) begin
                add_random_word(len, 3);
            end
        end
        close_vocab();
    endtask

    task automatic pad_query(input int len);
        int k;
        word_model[len] = 8'h00;
        for (k = len + 1; k < 16; k++) begin
            word_model[k] = rand_letter(4);
        end
    endtask

    task automatic query_from_word(input int w);
        int k;
        for (k = 0; k < word_len[w]; k++) begin
            word_model[k] = vocab_model[word_start[w] + k];
        end
        pad_query(word_len[w]);
    endtask

    task automatic query_from_string(input string s);
        int k;
        for (k = 0; k < s.len(); k++) begin
            word_model[k] = s[k];
        end
        pad_query(s.len());
    endtask

    task automatic load_memories();
        int a;
        for (a = 0; a < 64; a++) begin
            wb_write(`VOCAB_BASE + a, vocab_model[a]);
        end
        for (a = 0; a < 16; a++) begin
            wb_write(`WORD_BASE + a, word_model[a]);
        end
    endtask

    // first index whose complete word equals the query
    function automatic void model_lookup(output logic found, output int index);
        int  p;
        int  e;
        int  k;
        int  ql;
        int  idx;
        logic same;
        found = 1'b0;
        index = 0;
        ql    = 0;
        while (ql < 16 && word_model[ql] != 8'h00) begin
            ql++;
        end
        p   = 0;
        idx = 0;
        while (p < 64 && vocab_model[p] != 8'h00) begin
            e = p;
            while (e < 64 && vocab_model[e] != 8'h00) begin
                e++;
            end
            // unterminated word at the end of memory
            if (e == 64) begin
                return;
            end
            same = (ql > 0) && (e - p == ql);
            for (k = 0; k < ql; k++) begin
                if (vocab_model[p + k] != word_model[k]) begin
                    same = 1'b0;
                end
            end
            if (same) begin
                found = 1'b1;
                index = idx;
                return;
            end
            p = e + 1;
            idx++;
        end
    endfunction

    task automatic wait_done(output logic [7:0] st);
        do wb_read(`STATUS_ADDR, st); while (!st[1]);
    endtask

    task automatic check_outcome(input string what);
        logic [7:0] st;
        logic [7:0] res;
        logic       exp_found;
        int         exp_index;
        model_lookup(exp_found, exp_index);
        wait_done(st);
        wb_read(`RESULT_ADDR, res);
        check_value(st[0], 1'b0, {what, " busy after done"});
        check_value(st[2], exp_found, {what, " found"});
        if (exp_found) begin
            check_value(res, exp_index, {what, " index"});
        end
    endtask

    task automatic search(input string what);
        wb_write(`CTRL_ADDR, 8'h01);
        check_outcome(what);
    endtask

    initial begin
        logic [7:0] st;
        logic [7:0] res;
        int         n;
        int         len;
        int         dpos;
        int         k;
        int         errs;

        rst         = 1'b1;
        wb_req      = '0;
        lcg_state   = 32'd65476;
        check_count = 0;
        error_count = 0;
        cycle_count = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        errs = error_count;
        wb_read(`STATUS_ADDR, st);
        check_value(st, 8'h00, "status after reset");
        wb_read(`RESULT_ADDR, res);
        check_value(res, 8'h00, "result after reset");
        end_test("reset values", errs);

        errs = error_count;
        for (n = 0; n < 20; n++) begin
            build_vocab(rand_range(3, 8), 1, 4);
            query_from_word(rand_range(0, word_count - 1));
            load_memories();
            search("hit");
        end
        end_test("random hits", errs);

        errs = error_count;
        for (n = 0; n < 8; n++) begin
            build_vocab(rand_range(3, 8), 1, 4);
            len  = rand_range(1, 5);
            dpos = rand_range(0, len - 1);
            for (k = 0; k < len; k++) begin
                word_model[k] = (k == dpos) ? 8'h64 : rand_letter(3);
            end
            pad_query(len);
            load_memories();
            search("miss");
        end
        end_test("random misses", errs);

        errs = error_count;
        new_vocab();
        add_word("ab");
        add_word("abca");
        add_word("abcb");
        add_word("a");
        add_word("abc");
        add_word("abc");
        close_vocab();
        query_from_string("abc");
        load_memories();
        search("prefix and extension");
        query_from_string("");
        load_memories();
        search("empty query");
        vocab_model[0] = 8'h00;
        query_from_string("a");
        load_memories();
        search("empty vocabulary");
        end_test("prefix and empty cases", errs);

        errs = error_count;
        new_vocab();
        while (vocab_pos < 56) begin
            add_random_word(rand_range(1, 4), 2);
        end
        len = 64 - vocab_pos;
        while (vocab_pos < 64) begin
            put_char("c");
        end
        for (k = 0; k < len; k++) begin
            word_model[k] = "c";
        end
        pad_query(len);
        load_memories();
        search("overflow tail");
        query_from_word(rand_range(0, word_count - 1));
        load_memories();
        search("overflow earlier word");
        end_test("overflow", errs);

        errs = error_count;
        build_vocab(10, 3, 4);
        query_from_string("d");
        load_memories();
        wb_write(`CTRL_ADDR, 8'h01);
        wb_read(`STATUS_ADDR, st);
        check_value(st[0], 1'b1, "busy after start");
        // all three dropped while the walk is running
        wb_write(`CTRL_ADDR, 8'h01);
        wb_write(`VOCAB_BASE, 8'h64);
        wb_write(`VOCAB_BASE + 1, 8'h00);
        wb_read(`STATUS_ADDR, st);
        check_value(st[0], 1'b1, "still busy after dropped writes");
        check_outcome("busy search");
        search("search after dropped writes");
        end_test("busy rules", errs);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+verilog
verilog/wb_pkg.sv
verilog/match_pkg.sv
verilog/sram.sv
verilog/char_incr.sv
verilog/matcher.sv
verilog/wb_regs.sv
verilog/word_match_top.sv
testbench/tb_word_match.sv
